//--- rtl/xgmii_pkg.sv
// widths, XGMII characters, lane codes and FSM state types shared by the XGMII loop design
package xgmii_pkg;

    // packet beat layout
    localparam int DATA_W  = 64;
    localparam int LANES   = 8;
    localparam int EMPTY_W = 3;

    // packet FIFO sizing
    localparam int FIFO_DEPTH = 8;
    localparam int CNT_W      = 4;

    // XGMII control characters
    localparam logic [7:0] CH_IDLE  = 8'h07;
    localparam logic [7:0] CH_START = 8'hFB;
    localparam logic [7:0] CH_TERM  = 8'hFD;
    localparam logic [7:0] CH_ERROR = 8'hFE;

    // preamble bytes, sent as data
    localparam logic [7:0] CH_PREAMBLE = 8'h55;
    localparam logic [7:0] CH_SFD      = 8'hD5;

    // what a lane puts on the wire in the next column
    typedef enum logic [1:0] {
        LC_DATA  = 2'd0,
        LC_IDLE  = 2'd1,
        LC_START = 2'd2,
        LC_TERM  = 2'd3
    } lane_code_t;

    typedef enum logic [1:0] {
        TX_IDLE     = 2'd0,
        TX_PREAMBLE = 2'd1,
        TX_DATA     = 2'd2,
        TX_TERM     = 2'd3
    } tx_state_t;

    typedef enum logic {
        RX_IDLE  = 1'b0,
        RX_FRAME = 1'b1
    } rx_state_t;

endpackage

//--- rtl/pkt_credit_fifo.sv
// packet FIFO with per-pop credit return and a count of whole stored packets
`timescale 1ns/1ps

module pkt_credit_fifo (
    input  logic                             tx_clk_156,
    input  logic                             rst_n_i,
    input  logic                             in_valid_i,
    input  logic [xgmii_pkg::DATA_W-1:0]     in_data_i,
    input  logic                             in_sop_i,
    input  logic                             in_eop_i,
    input  logic [xgmii_pkg::EMPTY_W-1:0]    in_empty_i,
    input  logic                             pop_i,
    output logic [xgmii_pkg::DATA_W-1:0]     head_data_o,
    output logic                             head_sop_o,
    output logic                             head_eop_o,
    output logic [xgmii_pkg::EMPTY_W-1:0]    head_empty_o,
    output logic                             pkt_ready_o,
    output logic                             credit_o
);

    logic [xgmii_pkg::DATA_W-1:0]            data_mem  [xgmii_pkg::FIFO_DEPTH];
    logic                                    sop_mem   [xgmii_pkg::FIFO_DEPTH];
    logic                                    eop_mem   [xgmii_pkg::FIFO_DEPTH];
    logic [xgmii_pkg::EMPTY_W-1:0]           empty_mem [xgmii_pkg::FIFO_DEPTH];

    logic [$clog2(xgmii_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(xgmii_pkg::FIFO_DEPTH)-1:0] rd_ptr;
    logic [xgmii_pkg::CNT_W-1:0]              occ_cnt;
    logic [xgmii_pkg::CNT_W-1:0]              pkt_cnt;
    logic                                     push;
    logic                                     pop;

    // the source holds credits, so these guards only trip on a protocol error
    assign push = in_valid_i && (occ_cnt != xgmii_pkg::FIFO_DEPTH);
    assign pop  = pop_i && (occ_cnt != '0);

    assign head_data_o  = data_mem[rd_ptr];
    assign head_sop_o   = sop_mem[rd_ptr];
    assign head_eop_o   = eop_mem[rd_ptr];
    assign head_empty_o = empty_mem[rd_ptr];
    assign pkt_ready_o  = (pkt_cnt != '0);

    always_ff @(posedge tx_clk_156) begin
        if (push) begin
            data_mem[wr_ptr]  <= in_data_i;
            sop_mem[wr_ptr]   <= in_sop_i;
            eop_mem[wr_ptr]   <= in_eop_i;
            empty_mem[wr_ptr] <= in_empty_i;
        end
    end

    always_ff @(posedge tx_clk_156 or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            occ_cnt  <= '0;
            pkt_cnt  <= '0;
            credit_o <= 1'b0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   occ_cnt <= occ_cnt + 1'b1;
                2'b01:   occ_cnt <= occ_cnt - 1'b1;
                default: occ_cnt <= occ_cnt;
            endcase
            // whole packets, counted by eop beats in and out
            case ({push && in_eop_i, pop && head_eop_o})
                2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
                2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
                default: pkt_cnt <= pkt_cnt;
            endcase
            credit_o <= pop;
        end
    end

endmodule

//--- rtl/xgmii_tx_framer.sv
// transmit framer FSM producing per-lane codes and bytes from stored packets
`timescale 1ns/1ps

module xgmii_tx_framer (
    input  logic                                              tx_clk_156,
    input  logic                                              rst_n_i,
    input  logic                                              pkt_ready_i,
    input  logic [xgmii_pkg::DATA_W-1:0]                      head_data_i,
    input  logic                                              head_eop_i,
    input  logic [xgmii_pkg::EMPTY_W-1:0]                     head_empty_i,
    output logic                                              pop_o,
    output xgmii_pkg::lane_code_t [xgmii_pkg::LANES-1:0]      lane_code_o,
    output logic [xgmii_pkg::LANES-1:0][7:0]                  lane_byte_o
);

    xgmii_pkg::tx_state_t state;
    xgmii_pkg::tx_state_t state_nxt;

    always_ff @(posedge tx_clk_156 or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= xgmii_pkg::TX_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            xgmii_pkg::TX_IDLE: begin
                // a full packet must be stored before the frame may start
                if (pkt_ready_i) begin
                    state_nxt = xgmii_pkg::TX_PREAMBLE;
                end
            end
            xgmii_pkg::TX_PREAMBLE: begin
                state_nxt = xgmii_pkg::TX_DATA;
            end
            xgmii_pkg::TX_DATA: begin
                if (head_eop_i) begin
                    if (head_empty_i == '0) begin
                        state_nxt = xgmii_pkg::TX_TERM;
                    end else begin
                        state_nxt = xgmii_pkg::TX_IDLE;
                    end
                end
            end
            xgmii_pkg::TX_TERM: begin
                state_nxt = xgmii_pkg::TX_IDLE;
            end
            default: begin
                state_nxt = xgmii_pkg::TX_IDLE;
            end
        endcase
    end

    // one beat per data column, never stalls inside a frame
    assign pop_o = (state == xgmii_pkg::TX_DATA);

    always_comb begin
        for (int i = 0; i < xgmii_pkg::LANES; i++) begin
            lane_byte_o[i] = head_data_i[8*i +: 8];
            lane_code_o[i] = xgmii_pkg::LC_IDLE;
            case (state)
                xgmii_pkg::TX_PREAMBLE: begin
                    if (i == 0) begin
                        lane_code_o[i] = xgmii_pkg::LC_START;
                    end else begin
                        lane_code_o[i] = xgmii_pkg::LC_DATA;
                        if (i == xgmii_pkg::LANES - 1) begin
                            lane_byte_o[i] = xgmii_pkg::CH_SFD;
                        end else begin
                            lane_byte_o[i] = xgmii_pkg::CH_PREAMBLE;
                        end
                    end
                end
                xgmii_pkg::TX_DATA: begin
                    // lane 8-e gets terminate on a short last beat
                    if (!head_eop_i || (i + int'(head_empty_i) < xgmii_pkg::LANES)) begin
                        lane_code_o[i] = xgmii_pkg::LC_DATA;
                    end else if (i + int'(head_empty_i) == xgmii_pkg::LANES) begin
                        lane_code_o[i] = xgmii_pkg::LC_TERM;
                    end
                end
                xgmii_pkg::TX_TERM: begin
                    if (i == 0) begin
                        lane_code_o[i] = xgmii_pkg::LC_TERM;
                    end
                end
                default: begin
                    lane_code_o[i] = xgmii_pkg::LC_IDLE;
                end
            endcase
        end
    end

endmodule

//--- rtl/xgmii_lane_enc.sv
// registered character and control encoder for a single XGMII lane
`timescale 1ns/1ps

module xgmii_lane_enc (
    input  logic                   tx_clk_156,
    input  logic                   rst_n_i,
    input  xgmii_pkg::lane_code_t  code_i,
    input  logic [7:0]             byte_i,
    output logic [7:0]             txd_o,
    output logic                   txc_o
);

    always_ff @(posedge tx_clk_156 or negedge rst_n_i) begin
        if (!rst_n_i) begin
            txd_o <= xgmii_pkg::CH_IDLE;
            txc_o <= 1'b1;
        end else begin
            // control bit set for every code but data
            txc_o <= (code_i != xgmii_pkg::LC_DATA);
            case (code_i)
                xgmii_pkg::LC_DATA:  txd_o <= byte_i;
                xgmii_pkg::LC_START: txd_o <= xgmii_pkg::CH_START;
                xgmii_pkg::LC_TERM:  txd_o <= xgmii_pkg::CH_TERM;
                default:             txd_o <= xgmii_pkg::CH_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/xgmii_rx_deframer.sv
// receive deframer turning XGMII columns into packet beats with eop, empty and error
`timescale 1ns/1ps

module xgmii_rx_deframer (
    input  logic                             tx_clk_156,
    input  logic                             rst_n_i,
    input  logic [xgmii_pkg::DATA_W-1:0]     xgmii_rx_data_i,
    input  logic [xgmii_pkg::LANES-1:0]      xgmii_rx_control_i,
    output logic                             out_valid_o,
    output logic [xgmii_pkg::DATA_W-1:0]     out_data_o,
    output logic                             out_sop_o,
    output logic                             out_eop_o,
    output logic [xgmii_pkg::EMPTY_W-1:0]    out_empty_o,
    output logic                             out_error_o
);

    xgmii_pkg::rx_state_t                 state;
    logic [xgmii_pkg::LANES-1:0][7:0]     rxd_q;
    logic [xgmii_pkg::LANES-1:0]          rxc_q;

    logic                                 start_col;
    logic                                 term_lane0;
    logic                                 term_found;
    logic [xgmii_pkg::EMPTY_W-1:0]        term_empty;
    logic                                 col_err;
    logic                                 eop_now;

    logic                                 hold_valid;
    logic [xgmii_pkg::DATA_W-1:0]         hold_data;
    logic                                 hold_sop;
    logic                                 hold_eop;
    logic [xgmii_pkg::EMPTY_W-1:0]        hold_empty;
    logic                                 hold_err;
    logic                                 err_sticky;
    logic                                 sop_pend;

    assign start_col  = rxc_q[0] && (rxd_q[0] == xgmii_pkg::CH_START);
    assign term_lane0 = rxc_q[0] && (rxd_q[0] == xgmii_pkg::CH_TERM);

    // first terminate in the column, and any other control byte before it
    always_comb begin
        term_found = 1'b0;
        term_empty = '0;
        col_err    = 1'b0;
        for (int i = 0; i < xgmii_pkg::LANES; i++) begin
            if (!term_found && rxc_q[i]) begin
                if (rxd_q[i] == xgmii_pkg::CH_TERM) begin
                    term_found = 1'b1;
                    term_empty = (xgmii_pkg::EMPTY_W)'(xgmii_pkg::LANES - i);
                end else begin
                    col_err = 1'b1;
                end
            end
        end
    end

    // terminate alone in lane 0 closes the beat already held
    assign eop_now = (state == xgmii_pkg::RX_FRAME) && term_lane0;

    assign out_valid_o = hold_valid;
    assign out_data_o  = hold_data;
    assign out_sop_o   = hold_valid && hold_sop;
    assign out_eop_o   = hold_valid && (hold_eop || eop_now);
    assign out_empty_o = hold_empty;
    assign out_error_o = out_eop_o && hold_err;

    always_ff @(posedge tx_clk_156) begin
        rxd_q <= xgmii_rx_data_i;
        if (state == xgmii_pkg::RX_FRAME && !term_lane0) begin
            hold_data  <= rxd_q;
            hold_empty <= term_found ? term_empty : '0;
        end
    end

    always_ff @(posedge tx_clk_156 or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rxc_q      <= '0;
            state      <= xgmii_pkg::RX_IDLE;
            hold_valid <= 1'b0;
            hold_sop   <= 1'b0;
            hold_eop   <= 1'b0;
            hold_err   <= 1'b0;
            err_sticky <= 1'b0;
            sop_pend   <= 1'b0;
        end else begin
            rxc_q      <= xgmii_rx_control_i;
            hold_valid <= 1'b0;
            hold_eop   <= 1'b0;
            case (state)
                xgmii_pkg::RX_IDLE: begin
                    // start column also carries the preamble, skip it whole
                    if (start_col) begin
                        state      <= xgmii_pkg::RX_FRAME;
                        err_sticky <= 1'b0;
                        sop_pend   <= 1'b1;
                    end
                end
                default: begin
                    if (term_lane0) begin
                        state <= xgmii_pkg::RX_IDLE;
                    end else begin
                        hold_valid <= 1'b1;
                        hold_sop   <= sop_pend;
                        hold_err   <= err_sticky || col_err;
                        err_sticky <= err_sticky || col_err;
                        sop_pend   <= 1'b0;
                        if (term_found) begin
                            hold_eop <= 1'b1;
                            state    <= xgmii_pkg::RX_IDLE;
                        end
                    end
                end
            endcase
        end
    end

endmodule

//--- rtl/xgmii_loop_top.sv
// top level with packet FIFO, transmit framer, eight lane encoders and receive deframer
`timescale 1ns/1ps

module xgmii_loop_top (
    input  logic                             tx_clk_156,
    input  logic                             rst_n_i,
    input  logic                             in_valid_i,
    input  logic [xgmii_pkg::DATA_W-1:0]     in_data_i,
    input  logic                             in_sop_i,
    input  logic                             in_eop_i,
    input  logic [xgmii_pkg::EMPTY_W-1:0]    in_empty_i,
    output logic                             in_credit_o,
    output logic [xgmii_pkg::DATA_W-1:0]     xgmii_tx_data_o,
    output logic [xgmii_pkg::LANES-1:0]      xgmii_tx_control_o,
    input  logic [xgmii_pkg::DATA_W-1:0]     xgmii_rx_data_i,
    input  logic [xgmii_pkg::LANES-1:0]      xgmii_rx_control_i,
    output logic                             out_valid_o,
    output logic [xgmii_pkg::DATA_W-1:0]     out_data_o,
    output logic                             out_sop_o,
    output logic                             out_eop_o,
    output logic [xgmii_pkg::EMPTY_W-1:0]    out_empty_o,
    output logic                             out_error_o
);

    logic [xgmii_pkg::DATA_W-1:0]                     head_data;
    logic                                             head_eop;
    logic [xgmii_pkg::EMPTY_W-1:0]                    head_empty;
    logic                                             pkt_ready;
    logic                                             pop;
    xgmii_pkg::lane_code_t [xgmii_pkg::LANES-1:0]     lane_code;
    logic [xgmii_pkg::LANES-1:0][7:0]                 lane_byte;

    // sop is implied by frame start in the framer
    pkt_credit_fifo tx_fifo (
        .tx_clk_156   (tx_clk_156),
        .rst_n_i      (rst_n_i),
        .in_valid_i   (in_valid_i),
        .in_data_i    (in_data_i),
        .in_sop_i     (in_sop_i),
        .in_eop_i     (in_eop_i),
        .in_empty_i   (in_empty_i),
        .pop_i        (pop),
        .head_data_o  (head_data),
        .head_sop_o   (),
        .head_eop_o   (head_eop),
        .head_empty_o (head_empty),
        .pkt_ready_o  (pkt_ready),
        .credit_o     (in_credit_o)
    );

    xgmii_tx_framer framer (
        .tx_clk_156   (tx_clk_156),
        .rst_n_i      (rst_n_i),
        .pkt_ready_i  (pkt_ready),
        .head_data_i  (head_data),
        .head_eop_i   (head_eop),
        .head_empty_i (head_empty),
        .pop_o        (pop),
        .lane_code_o  (lane_code),
        .lane_byte_o  (lane_byte)
    );

    for (genvar i = 0; i < xgmii_pkg::LANES; i++) begin : g_lane
        xgmii_lane_enc lane_enc (
            .tx_clk_156 (tx_clk_156),
            .rst_n_i    (rst_n_i),
            .code_i     (lane_code[i]),
            .byte_i     (lane_byte[i]),
            .txd_o      (xgmii_tx_data_o[8*i +: 8]),
            .txc_o      (xgmii_tx_control_o[i])
        );
    end

    xgmii_rx_deframer deframer (
        .tx_clk_156         (tx_clk_156),
        .rst_n_i            (rst_n_i),
        .xgmii_rx_data_i    (xgmii_rx_data_i),
        .xgmii_rx_control_i (xgmii_rx_control_i),
        .out_valid_o        (out_valid_o),
        .out_data_o         (out_data_o),
        .out_sop_o          (out_sop_o),
        .out_eop_o          (out_eop_o),
        .out_empty_o        (out_empty_o),
        .out_error_o        (out_error_o)
    );

endmodule

//--- testbench/xgmii_loop_assertions.sv
// concurrent assertions on credit pulses and idle columns between XGMII frames
`timescale 1ns/1ps

module xgmii_loop_assertions (
    input logic        tx_clk_156,
    input logic        rst_n_i,
    input logic        in_credit_o,
    input logic [63:0] xgmii_tx_data_o,
    input logic [7:0]  xgmii_tx_control_o
);

    logic in_gap;
    logic start_col;
    logic term_col;
    logic idle_col;

    assign start_col = xgmii_tx_control_o[0] && (xgmii_tx_data_o[7:0] == xgmii_pkg::CH_START);
    assign idle_col  = (xgmii_tx_data_o == {8{xgmii_pkg::CH_IDLE}}) && (xgmii_tx_control_o == 8'hFF);

    always_comb begin
        term_col = 1'b0;
        for (int i = 0; i < xgmii_pkg::LANES; i++) begin
            if (xgmii_tx_control_o[i] && xgmii_tx_data_o[8*i +: 8] == xgmii_pkg::CH_TERM) begin
                term_col = 1'b1;
            end
        end
    end

    // between terminate and the next start
    always_ff @(posedge tx_clk_156 or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_gap <= 1'b1;
        end else if (start_col) begin
            in_gap <= 1'b0;
        end else if (term_col) begin
            in_gap <= 1'b1;
        end
    end

    a_credit_in_reset: assert property (@(posedge tx_clk_156) !rst_n_i |-> !in_credit_o)
        else $error("credit pulse while in reset");

    a_gap_idle: assert property (@(posedge tx_clk_156) disable iff (!rst_n_i)
        (in_gap && !start_col) |-> idle_col)
        else $error("column between frames is not all idle");

endmodule

bind xgmii_loop_top xgmii_loop_assertions asrt0 (
    .tx_clk_156         (tx_clk_156),
    .rst_n_i            (rst_n_i),
    .in_credit_o        (in_credit_o),
    .xgmii_tx_data_o    (xgmii_tx_data_o),
    .xgmii_tx_control_o (xgmii_tx_control_o)
);

//--- testbench/xgmii_loop_checker.sv
// checker comparing XGMII transmit framing, credits and received packets with expected values
`timescale 1ns/1ps

module xgmii_loop_checker (
    input  logic        tx_clk_156,
    input  logic        rst_n_i,
    input  logic        in_valid_i,
    input  logic        in_credit_i,
    input  logic [63:0] tx_data_i,
    input  logic [7:0]  tx_ctrl_i,
    input  logic        out_valid_i,
    input  logic [63:0] out_data_i,
    input  logic        out_sop_i,
    input  logic        out_eop_i,
    input  logic [2:0]  out_empty_i,
    input  logic        out_error_i,
    input  logic        finish_i,
    input  int          beats_sent_i,
    output int          tests_done_o,
    output int          errors_o
);

    // filled by the testbench, one entry per beat or per frame
    logic [63:0] exp_data[$];
    logic        exp_sop[$];
    logic        exp_eop[$];
    logic [2:0]  exp_empty[$];
    logic        exp_err[$];
    int          exp_tx_len[$];

    int   errors = 0;
    int   tests_done = 0;
    int   tests_bad = 0;
    logic pkt_bad = 1'b0;
    int   avail;
    int   credit_cnt;
    logic tx_in_frame;
    logic prev_idle;
    int   tx_bytes;
    int   tx_frame = 0;

    assign tests_done_o = tests_done;
    assign errors_o     = errors;

    task automatic fail_now(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        errors++;
    endtask

    // source must own a credit for every beat
    always @(posedge tx_clk_156 or negedge rst_n_i) begin
        if (!rst_n_i) begin
            avail      = xgmii_pkg::FIFO_DEPTH;
            credit_cnt = 0;
        end else begin
            if (in_valid_i && avail <= 0) begin
                fail_now("beat sent without a credit");
            end
            avail      = avail - int'(in_valid_i) + int'(in_credit_i);
            credit_cnt = credit_cnt + int'(in_credit_i);
        end
    end

    always @(posedge tx_clk_156 or negedge rst_n_i) begin
        int  k;
        int  exp_len;
        if (!rst_n_i) begin
            tx_in_frame = 1'b0;
            prev_idle   = 1'b1;
        end else if (!tx_in_frame) begin
            if (tx_ctrl_i[0] && tx_data_i[7:0] == xgmii_pkg::CH_START) begin
                if (tx_data_i != 64'hD5555555555555FB || tx_ctrl_i != 8'h01) begin
                    fail_now($sformatf("frame %0d bad start column %h", tx_frame, tx_data_i));
                end
                if (!prev_idle) begin
                    fail_now($sformatf("frame %0d start without idle column", tx_frame));
                end
                tx_in_frame = 1'b1;
                tx_bytes    = 0;
            end
        end else begin
            k = 8;
            for (int i = 7; i >= 0; i--) begin
                if (tx_ctrl_i[i]) begin
                    k = i;
                end
            end
            tx_bytes += k;
            if (k < 8) begin
                if (tx_data_i[8*k +: 8] != xgmii_pkg::CH_TERM) begin
                    fail_now($sformatf("frame %0d lane %0d not terminate", tx_frame, k));
                end
                for (int i = k + 1; i < 8; i++) begin
                    if (!tx_ctrl_i[i] || tx_data_i[8*i +: 8] != xgmii_pkg::CH_IDLE) begin
                        fail_now($sformatf("frame %0d lane %0d not idle", tx_frame, i));
                    end
                end
                exp_len = (exp_tx_len.size() > 0) ? exp_tx_len.pop_front() : -1;
                if (tx_bytes != exp_len) begin
                    fail_now($sformatf("frame %0d has %0d bytes, expected %0d",
                        tx_frame, tx_bytes, exp_len));
                end
                tx_in_frame = 1'b0;
                tx_frame++;
            end
        end
        prev_idle = (tx_data_i == {8{xgmii_pkg::CH_IDLE}}) && (tx_ctrl_i == 8'hFF);
    end

    always @(posedge tx_clk_156) begin
        logic [63:0] d;
        logic [2:0]  e;
        logic        s;
        logic        l;
        logic        r;
        if (rst_n_i && out_valid_i) begin
            if (exp_data.size() == 0) begin
                fail_now("received a beat that was not expected");
                pkt_bad = 1'b1;
            end else begin
                d = exp_data.pop_front();
                s = exp_sop.pop_front();
                l = exp_eop.pop_front();
                e = exp_empty.pop_front();
                r = exp_err.pop_front();
                for (int i = 0; i < 8; i++) begin
                    // unused lanes of a last beat are not compared
                    if ((!l || i < 8 - int'(e)) && out_data_i[8*i +: 8] != d[8*i +: 8]) begin
                        fail_now($sformatf("test %0d byte %0d is %h, expected %h",
                            tests_done, i, out_data_i[8*i +: 8], d[8*i +: 8]));
                        pkt_bad = 1'b1;
                    end
                end
                if (out_sop_i != s || out_eop_i != l || out_error_i != r
                    || (l && out_empty_i != e)) begin
                    fail_now($sformatf("test %0d flags sop %b eop %b empty %0d err %b",
                        tests_done, out_sop_i, out_eop_i, out_empty_i, out_error_i));
                    pkt_bad = 1'b1;
                end
            end
            if (out_eop_i) begin
                $display("test %0d: %s", tests_done, pkt_bad ? "failed" : "passed");
                if (pkt_bad) begin
                    tests_bad++;
                end
                tests_done++;
                pkt_bad = 1'b0;
            end
        end
    end

    always @(posedge finish_i) begin
        if (credit_cnt != beats_sent_i) begin
            fail_now($sformatf("%0d credits returned for %0d beats", credit_cnt, beats_sent_i));
        end
        $display("tests: %0d passed, %0d failed, %0d errors",
            tests_done - tests_bad, tests_bad, errors);
    end

endmodule

//--- testbench/tb_xgmii_loop.sv
// testbench top with clock, reset, file-driven stimulus, credit tracking and XGMII loop wiring
`timescale 1ns/1ps

module tb_xgmii_loop;

    localparam int MAX_TESTS = 32;
    localparam int TIMEOUT   = 2000;

    logic        tx_clk_156;
    logic        rst_n_i;
    logic        in_valid_i;
    logic [63:0] in_data_i;
    logic        in_sop_i;
    logic        in_eop_i;
    logic [2:0]  in_empty_i;
    logic        in_credit_o;
    logic [63:0] tx_data;
    logic [7:0]  tx_ctrl;
    logic [63:0] rx_data;
    logic [7:0]  rx_ctrl;
    logic        out_valid_o;
    logic [63:0] out_data_o;
    logic        out_sop_o;
    logic        out_eop_o;
    logic [2:0]  out_empty_o;
    logic        out_error_o;

    integer seed;
    int     n_tests;
    int     beats_sent;
    int     credits_back;
    int     tests_done;
    int     errors;
    logic   finish;
    logic   inject;
    int     frame_cnt;
    int     test_len[MAX_TESTS];
    int     test_gap[MAX_TESTS];
    logic   corrupt_arr[MAX_TESTS];

    xgmii_loop_top dut0 (
        .tx_clk_156(tx_clk_156), .rst_n_i(rst_n_i),
        .in_valid_i(in_valid_i), .in_data_i(in_data_i), .in_sop_i(in_sop_i),
        .in_eop_i(in_eop_i), .in_empty_i(in_empty_i), .in_credit_o(in_credit_o),
        .xgmii_tx_data_o(tx_data), .xgmii_tx_control_o(tx_ctrl),
        .xgmii_rx_data_i(rx_data), .xgmii_rx_control_i(rx_ctrl),
        .out_valid_o(out_valid_o), .out_data_o(out_data_o), .out_sop_o(out_sop_o),
        .out_eop_o(out_eop_o), .out_empty_o(out_empty_o), .out_error_o(out_error_o)
    );

    xgmii_loop_checker chk0 (
        .tx_clk_156(tx_clk_156), .rst_n_i(rst_n_i),
        .in_valid_i(in_valid_i), .in_credit_i(in_credit_o),
        .tx_data_i(tx_data), .tx_ctrl_i(tx_ctrl),
        .out_valid_i(out_valid_o), .out_data_i(out_data_o), .out_sop_i(out_sop_o),
        .out_eop_i(out_eop_o), .out_empty_i(out_empty_o), .out_error_i(out_error_o),
        .finish_i(finish), .beats_sent_i(beats_sent),
        .tests_done_o(tests_done), .errors_o(errors)
    );

    initial begin
        tx_clk_156 = 1'b0;
        forever #2 tx_clk_156 = ~tx_clk_156;
    end

    always @(posedge tx_clk_156 or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credits_back <= 0;
        end else if (in_credit_o) begin
            credits_back <= credits_back + 1;
        end
    end

    // flag the first data column of a frame marked corrupt
    always @(posedge tx_clk_156 or negedge rst_n_i) begin
        if (!rst_n_i) begin
            inject    <= 1'b0;
            frame_cnt <= 0;
        end else if (tx_ctrl[0] && tx_data[7:0] == xgmii_pkg::CH_START) begin
            inject    <= (frame_cnt < MAX_TESTS) ? corrupt_arr[frame_cnt] : 1'b0;
            frame_cnt <= frame_cnt + 1;
        end else begin
            inject <= 1'b0;
        end
    end

    assign rx_data = inject ? {tx_data[63:32], xgmii_pkg::CH_ERROR, tx_data[23:0]} : tx_data;
    assign rx_ctrl = inject ? (tx_ctrl | 8'h08) : tx_ctrl;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic read_tests();
        int    fd;
        int    l;
        int    g;
        int    c;
        string line;
        fd = $fopen("testbench/xgmii_loop_tests.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the tests file");
        end
        while (!$feof(fd) && n_tests < MAX_TESTS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#") begin
                if ($sscanf(line, "%d %d %d", l, g, c) == 3) begin
                    test_len[n_tests]    = l;
                    test_gap[n_tests]    = g;
                    corrupt_arr[n_tests] = (c != 0);
                    n_tests++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic send_packet(input int t);
        int          nb;
        int          idx;
        int          waited;
        integer      rnd;
        logic [63:0] d[8];
        logic [63:0] e;
        nb = (test_len[t] + 7) / 8;
        for (int j = 0; j < nb; j++) begin
            d[j] = '0;
            e    = '0;
            for (int i = 0; i < 8; i++) begin
                idx = j * 8 + i;
                if (idx < test_len[t]) begin
                    rnd           = $random(seed);
                    d[j][8*i +: 8] = rnd[7:0];
                    e[8*i +: 8]    = (corrupt_arr[t] && idx == 3) ? xgmii_pkg::CH_ERROR : rnd[7:0];
                end
            end
            chk0.exp_data.push_back(e);
            chk0.exp_sop.push_back(j == 0);
            chk0.exp_eop.push_back(j == nb - 1);
            chk0.exp_empty.push_back((j == nb - 1) ? 3'(nb * 8 - test_len[t]) : 3'd0);
            chk0.exp_err.push_back(corrupt_arr[t] && j == nb - 1);
        end
        chk0.exp_tx_len.push_back(test_len[t]);
        for (int j = 0; j < nb; j++) begin
            waited = 0;
            while (xgmii_pkg::FIFO_DEPTH - beats_sent + credits_back <= 0) begin
                in_valid_i = 1'b0;
                @(negedge tx_clk_156);
                waited++;
                if (waited > TIMEOUT) begin
                    abort_run("timeout waiting for a credit to come back to the source");
                end
            end
            in_valid_i = 1'b1;
            in_data_i  = d[j];
            in_sop_i   = (j == 0);
            in_eop_i   = (j == nb - 1);
            in_empty_i = (j == nb - 1) ? 3'(nb * 8 - test_len[t]) : 3'd0;
            beats_sent++;
            @(negedge tx_clk_156);
        end
        in_valid_i = 1'b0;
        in_sop_i   = 1'b0;
        in_eop_i   = 1'b0;
        in_empty_i = '0;
    endtask

    initial begin
        int waited;
        seed       = 32'h7330eaa6;
        rst_n_i    = 1'b0;
        in_valid_i = 1'b0;
        in_data_i  = '0;
        in_sop_i   = 1'b0;
        in_eop_i   = 1'b0;
        in_empty_i = '0;
        finish     = 1'b0;
        beats_sent = 0;
        n_tests    = 0;
        for (int i = 0; i < MAX_TESTS; i++) begin
            corrupt_arr[i] = 1'b0;
        end
        read_tests();
        repeat (10) @(posedge tx_clk_156);
        @(negedge tx_clk_156);
        rst_n_i = 1'b1;
        for (int t = 0; t < n_tests; t++) begin
            repeat (test_gap[t]) @(negedge tx_clk_156);
            send_packet(t);
        end
        waited = 0;
        while (tests_done < n_tests) begin
            @(negedge tx_clk_156);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("timeout waiting for all packets on the receive side");
            end
        end
        // every beat sent must have its credit back before the totals are compared
        waited = 0;
        while (credits_back < beats_sent) begin
            @(negedge tx_clk_156);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("timeout waiting for the last credits to return");
            end
        end
        finish = 1'b1;
        repeat (2) @(negedge tx_clk_156);
        if (errors == 0 && tests_done == n_tests) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/xgmii_loop_tests.txt
# length_bytes gap_cycles corrupt_flag (decimal)
# last burst with gap 0 runs the source out of credits
64 3 0
61 2 0
8 1 0
4 5 0
37 2 1
13 0 0
33 4 0
64 0 0
64 0 0
57 0 1
64 0 0
40 0 0
9 0 0

//--- xgmii_loop.f
rtl/xgmii_pkg.sv
rtl/pkt_credit_fifo.sv
rtl/xgmii_tx_framer.sv
rtl/xgmii_lane_enc.sv
rtl/xgmii_rx_deframer.sv
rtl/xgmii_loop_top.sv
testbench/xgmii_loop_assertions.sv
testbench/xgmii_loop_checker.sv
testbench/tb_xgmii_loop.sv

//--- run_sim.sh
#!/bin/sh
# build and run the XGMII loop testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_xgmii_loop -f xgmii_loop.f -o sim_xgmii_loop

./obj_dir/sim_xgmii_loop > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    exit 0
fi
exit 1
